//--- source/fetch_pkg.sv
package fetch_pkg;

    // word and packet widths
    localparam int addr_w = 32;
    localparam int inst_w = 32;
    localparam int packet_w = 2 * inst_w;

    // byte offsets, typed as addresses so they add to a pc directly
    localparam logic [addr_w-1:0] fetch_step = 32'd8;
    localparam logic [addr_w-1:0] inst_bytes = 32'd4;

    // first fetch after reset
    localparam logic [addr_w-1:0] reset_pc = 32'hbfc0_0000;

    // packets held between bus and splitter
    localparam int queue_depth = 4;
    localparam int cnt_w = $clog2(queue_depth + 1);
    localparam int ptr_w = $clog2(queue_depth);

    // kind of redirect parked behind a waiting request
    typedef enum logic [1:0] {
        redir_none,
        redir_branch,
        redir_exc
    } redirect_kind_e;

    // halted after a misaligned target until the next redirect
    typedef enum logic {
        fetch_run,
        fetch_halt
    } fetch_state_e;

    // which instruction of the packet goes out next
    typedef enum logic {
        slot_first,
        slot_second
    } slot_e;

endpackage

//--- source/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             i_exc_valid,
    input  logic [fetch_pkg::addr_w-1:0]     i_exc_pc,
    input  logic                             i_branch_valid,
    input  logic [fetch_pkg::addr_w-1:0]     i_branch_pc,
    input  logic                             i_iresp_addr_ok,
    input  logic                             i_iresp_data_ok,
    input  logic [fetch_pkg::packet_w-1:0]   i_iresp_data,
    input  logic [fetch_pkg::cnt_w-1:0]      i_q_count,
    output logic                             o_ireq_valid,
    output logic [fetch_pkg::addr_w-1:0]     o_ireq_addr,
    output logic                             o_q_push,
    output logic [fetch_pkg::addr_w-1:0]     o_q_pc,
    output logic [fetch_pkg::packet_w-1:0]   o_q_data,
    output logic                             o_q_exc,
    output logic                             o_q_clear
);

    logic [fetch_pkg::addr_w-1:0] pc;
    logic [fetch_pkg::addr_w-1:0] saved_pc;
    fetch_pkg::redirect_kind_e    saved_kind;
    fetch_pkg::fetch_state_e      state;
    logic [fetch_pkg::cnt_w-1:0]  outstanding;
    logic [fetch_pkg::cnt_w-1:0]  outstanding_next;
    logic [fetch_pkg::cnt_w-1:0]  kill;
    logic [fetch_pkg::cnt_w:0]    used;

    // pcs of requests still waiting for data, in bus order
    logic [fetch_pkg::addr_w-1:0] pc_fifo [fetch_pkg::queue_depth];
    logic [fetch_pkg::ptr_w-1:0]  pf_wr;
    logic [fetch_pkg::ptr_w-1:0]  pf_rd;

    logic                         in_valid;
    logic [fetch_pkg::addr_w-1:0] in_pc;
    logic                         take_in;
    logic                         pending;
    logic                         accept;
    logic                         misaligned;
    logic                         exc_push;
    logic                         resp_push;
    logic                         apply_saved;

    // exception target always beats branch target
    assign in_valid = i_exc_valid | i_branch_valid;
    assign in_pc = i_exc_valid ? i_exc_pc : i_branch_pc;
    // a branch never replaces a parked exception
    assign take_in = i_exc_valid | (i_branch_valid & (saved_kind != fetch_pkg::redir_exc));

    assign misaligned = pc[1:0] != 2'b00;
    assign used = {1'b0, i_q_count} + {1'b0, outstanding};

    assign o_ireq_valid = (state == fetch_pkg::fetch_run) && !misaligned &&
                          (used < (fetch_pkg::cnt_w + 1)'(fetch_pkg::queue_depth));
    assign o_ireq_addr = pc;

    assign pending = o_ireq_valid & ~i_iresp_addr_ok;
    assign accept = o_ireq_valid & i_iresp_addr_ok;
    // a parked redirect only exists while its request waits, so this is the accept edge
    assign apply_saved = (saved_kind != fetch_pkg::redir_none) & ~pending;

    assign outstanding_next = outstanding + (fetch_pkg::cnt_w)'(accept)
                              - (fetch_pkg::cnt_w)'(i_iresp_data_ok);

    // stale beats and anything in the redirect cycle never reach the queue
    assign resp_push = i_iresp_data_ok & (kill == '0) & ~in_valid;
    assign exc_push = (state == fetch_pkg::fetch_run) & misaligned & ~in_valid;

    assign o_q_push = resp_push | exc_push;
    assign o_q_pc = exc_push ? pc : pc_fifo[pf_rd];
    assign o_q_data = exc_push ? '0 : i_iresp_data;
    assign o_q_exc = exc_push;
    assign o_q_clear = in_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= fetch_pkg::reset_pc;
            state <= fetch_pkg::fetch_run;
            saved_kind <= fetch_pkg::redir_none;
            outstanding <= '0;
            kill <= '0;
            pf_wr <= '0;
            pf_rd <= '0;
        end else begin
            outstanding <= outstanding_next;
            if (accept) begin
                pf_wr <= pf_wr + 1'b1;
            end
            if (i_iresp_data_ok) begin
                pf_rd <= pf_rd + 1'b1;
            end

            // everything still in flight belongs to the old stream
            if (in_valid || apply_saved) begin
                kill <= outstanding_next;
            end else if (i_iresp_data_ok && kill != '0) begin
                kill <= kill - 1'b1;
            end

            if (pending) begin
                if (take_in) begin
                    saved_kind <= i_exc_valid ? fetch_pkg::redir_exc : fetch_pkg::redir_branch;
                end
            end else if (take_in) begin
                pc <= in_pc;
                state <= fetch_pkg::fetch_run;
                saved_kind <= fetch_pkg::redir_none;
            end else if (apply_saved) begin
                pc <= saved_pc;
                state <= fetch_pkg::fetch_run;
                saved_kind <= fetch_pkg::redir_none;
            end else begin
                if (accept) begin
                    pc <= pc + fetch_pkg::fetch_step;
                end
                if (exc_push) begin
                    state <= fetch_pkg::fetch_halt;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pending && take_in) begin
            saved_pc <= in_pc;
        end
        if (accept) begin
            pc_fifo[pf_wr] <= pc;
        end
    end

    // bus handshake: a waiting request may not move or vanish
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        pending |=> o_ireq_valid && $stable(o_ireq_addr));

endmodule

//--- source/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             i_push,
    input  logic [fetch_pkg::addr_w-1:0]     i_pc,
    input  logic [fetch_pkg::packet_w-1:0]   i_data,
    input  logic                             i_exc,
    input  logic                             i_clear,
    input  logic                             i_pk_ready,
    output logic [fetch_pkg::cnt_w-1:0]      o_count,
    output logic                             o_pk_valid,
    output logic [fetch_pkg::addr_w-1:0]     o_pk_pc,
    output logic [fetch_pkg::packet_w-1:0]   o_pk_data,
    output logic                             o_pk_exc
);

    logic [fetch_pkg::addr_w-1:0]     mem_pc [fetch_pkg::queue_depth];
    logic [fetch_pkg::packet_w-1:0]   mem_data [fetch_pkg::queue_depth];
    logic [fetch_pkg::queue_depth-1:0] mem_exc;

    // extra msb tells full from empty
    logic [fetch_pkg::ptr_w:0] wr_ptr;
    logic [fetch_pkg::ptr_w:0] rd_ptr;

    logic mem_empty;
    logic pop;
    logic load;

    assign mem_empty = wr_ptr == rd_ptr;
    assign pop = o_pk_valid & i_pk_ready;
    // refill the head register when it is free or leaving
    assign load = ~mem_empty & (~o_pk_valid | i_pk_ready);

    always_ff @(posedge clk) begin
        if (reset || i_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            o_pk_valid <= 1'b0;
            o_count <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            o_pk_valid <= load | (o_pk_valid & ~i_pk_ready);

            // count covers the head register too
            if (i_push && !pop) begin
                o_count <= o_count + 1'b1;
            end else if (!i_push && pop) begin
                o_count <= o_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem_pc[wr_ptr[fetch_pkg::ptr_w-1:0]] <= i_pc;
            mem_data[wr_ptr[fetch_pkg::ptr_w-1:0]] <= i_data;
            mem_exc[wr_ptr[fetch_pkg::ptr_w-1:0]] <= i_exc;
        end
        if (load) begin
            o_pk_pc <= mem_pc[rd_ptr[fetch_pkg::ptr_w-1:0]];
            o_pk_data <= mem_data[rd_ptr[fetch_pkg::ptr_w-1:0]];
            o_pk_exc <= mem_exc[rd_ptr[fetch_pkg::ptr_w-1:0]];
        end
    end

    // producer credit must keep us from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        i_push |-> o_count < (fetch_pkg::cnt_w)'(fetch_pkg::queue_depth));

endmodule

//--- source/inst_split.sv
`timescale 1ns/1ps

module inst_split (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             i_pk_valid,
    input  logic [fetch_pkg::addr_w-1:0]     i_pk_pc,
    input  logic [fetch_pkg::packet_w-1:0]   i_pk_data,
    input  logic                             i_pk_exc,
    input  logic                             i_flush,
    input  logic                             i_inst_ready,
    output logic                             o_pk_ready,
    output logic                             o_inst_valid,
    output logic [fetch_pkg::addr_w-1:0]     o_inst_pc,
    output logic [fetch_pkg::inst_w-1:0]     o_inst_raw,
    output logic                             o_inst_exc
);

    fetch_pkg::slot_e                 slot;
    logic                             hold_valid;
    logic [fetch_pkg::addr_w-1:0]     hold_pc;
    logic [fetch_pkg::packet_w-1:0]   hold_data;
    logic                             hold_exc;

    logic last_slot;
    logic out_fire;

    // exception packets carry a single instruction
    assign last_slot = hold_exc | (slot == fetch_pkg::slot_second);
    assign out_fire = hold_valid & i_inst_ready;
    assign o_pk_ready = ~hold_valid | (out_fire & last_slot);

    assign o_inst_valid = hold_valid;
    assign o_inst_exc = hold_exc;

    always_comb begin
        if (slot == fetch_pkg::slot_second) begin
            o_inst_pc = hold_pc + fetch_pkg::inst_bytes;
            o_inst_raw = hold_data[fetch_pkg::packet_w-1:fetch_pkg::inst_w];
        end else begin
            o_inst_pc = hold_pc;
            o_inst_raw = hold_data[fetch_pkg::inst_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            // redirect drops the packet in hand
            hold_valid <= 1'b0;
            slot <= fetch_pkg::slot_first;
        end else if (o_pk_ready) begin
            hold_valid <= i_pk_valid;
            slot <= fetch_pkg::slot_first;
        end else if (out_fire) begin
            slot <= fetch_pkg::slot_second;
        end
    end

    always_ff @(posedge clk) begin
        if (o_pk_ready && i_pk_valid) begin
            hold_pc <= i_pk_pc;
            hold_data <= i_pk_data;
            hold_exc <= i_pk_exc;
        end
    end

    // output side may not change under back-pressure unless redirected
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        o_inst_valid && !i_inst_ready && !i_flush |=>
            o_inst_valid && $stable(o_inst_pc) && $stable(o_inst_raw) && $stable(o_inst_exc));

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             i_exc_valid,
    input  logic [fetch_pkg::addr_w-1:0]     i_exc_pc,
    input  logic                             i_branch_valid,
    input  logic [fetch_pkg::addr_w-1:0]     i_branch_pc,
    output logic                             o_ireq_valid,
    output logic [fetch_pkg::addr_w-1:0]     o_ireq_addr,
    input  logic                             i_iresp_addr_ok,
    input  logic                             i_iresp_data_ok,
    input  logic [fetch_pkg::packet_w-1:0]   i_iresp_data,
    output logic                             o_inst_valid,
    output logic [fetch_pkg::addr_w-1:0]     o_inst_pc,
    output logic [fetch_pkg::inst_w-1:0]     o_inst_raw,
    output logic                             o_inst_exc,
    input  logic                             i_inst_ready
);

    // pc generator to queue
    logic                           q_push;
    logic [fetch_pkg::addr_w-1:0]   q_pc;
    logic [fetch_pkg::packet_w-1:0] q_data;
    logic                           q_exc;
    logic                           q_clear;
    logic [fetch_pkg::cnt_w-1:0]    q_count;

    // queue to splitter
    logic                           pk_valid;
    logic [fetch_pkg::addr_w-1:0]   pk_pc;
    logic [fetch_pkg::packet_w-1:0] pk_data;
    logic                           pk_exc;
    logic                           pk_ready;

    pc_gen pc_gen0 (
        .clk, .reset, .i_exc_valid, .i_exc_pc, .i_branch_valid, .i_branch_pc,
        .i_iresp_addr_ok, .i_iresp_data_ok, .i_iresp_data, .i_q_count(q_count),
        .o_ireq_valid, .o_ireq_addr, .o_q_push(q_push), .o_q_pc(q_pc),
        .o_q_data(q_data), .o_q_exc(q_exc), .o_q_clear(q_clear)
    );

    fetch_queue fetch_queue0 (
        .clk, .reset, .i_push(q_push), .i_pc(q_pc), .i_data(q_data), .i_exc(q_exc),
        .i_clear(q_clear), .i_pk_ready(pk_ready), .o_count(q_count),
        .o_pk_valid(pk_valid), .o_pk_pc(pk_pc), .o_pk_data(pk_data), .o_pk_exc(pk_exc)
    );

    inst_split inst_split0 (
        .clk, .reset, .i_pk_valid(pk_valid), .i_pk_pc(pk_pc), .i_pk_data(pk_data),
        .i_pk_exc(pk_exc), .i_flush(q_clear), .i_inst_ready, .o_pk_ready(pk_ready),
        .o_inst_valid, .o_inst_pc, .o_inst_raw, .o_inst_exc
    );

endmodule

//--- verif/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker #(
    parameter logic [fetch_pkg::inst_w-1:0] key = '0
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          i_exc_valid,
    input  logic [fetch_pkg::addr_w-1:0]  i_exc_pc,
    input  logic                          i_branch_valid,
    input  logic [fetch_pkg::addr_w-1:0]  i_branch_pc,
    input  logic                          i_ireq_valid,
    input  logic                          i_addr_ok,
    input  logic                          i_inst_valid,
    input  logic                          i_inst_ready,
    input  logic [fetch_pkg::addr_w-1:0]  i_inst_pc,
    input  logic [fetch_pkg::inst_w-1:0]  i_inst_raw,
    input  logic                          i_inst_exc,
    output int                            o_delivered,
    output int                            o_errors,
    output logic                          o_halted
);

    logic [fetch_pkg::addr_w-1:0] exp_pc;
    // exception parked behind a waiting bus request
    logic saved_exc;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            o_errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        logic [fetch_pkg::inst_w-1:0] exp_raw;
        logic                         exp_exc;
        logic                         pending;
        if (reset) begin
            exp_pc = fetch_pkg::reset_pc;
            saved_exc = 1'b0;
            o_halted = 1'b0;
            o_delivered = 0;
            o_errors = 0;
        end else begin
            // a handshake in the redirect cycle still belongs to the old stream
            if (i_inst_valid && i_inst_ready) begin
                o_delivered++;
                if (o_halted) begin
                    o_errors++;
                    $display("at %0t: instruction at %h delivered after a misaligned fetch %s",
                             $time, i_inst_pc, "with no redirect in between");
                end else begin
                    exp_exc = exp_pc[1:0] != 2'b00;
                    exp_raw = exp_exc ? '0 : exp_pc ^ key;
                    compare("o_inst_pc", exp_pc, i_inst_pc);
                    compare("o_inst_raw", exp_raw, i_inst_raw);
                    compare("o_inst_exc", 32'(exp_exc), 32'(i_inst_exc));
                    o_halted = exp_exc;
                    exp_pc = exp_pc + fetch_pkg::inst_bytes;
                end
            end

            pending = i_ireq_valid && !i_addr_ok;
            if (i_exc_valid) begin
                exp_pc = i_exc_pc;
                o_halted = 1'b0;
            end else if (i_branch_valid) begin
                // a parked exception keeps its target
                if (!saved_exc) begin
                    exp_pc = i_branch_pc;
                end
                o_halted = 1'b0;
            end

            if (!pending) begin
                saved_exc = 1'b0;
            end else if (i_exc_valid) begin
                saved_exc = 1'b1;
            end
        end
    end

endmodule

//--- verif/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam logic [fetch_pkg::inst_w-1:0] mem_key = 32'h3c5a_96e1;
    localparam int n_rows = 9;
    // instructions awaited after the parked exception case
    localparam int parked_wait = 10;

    typedef struct packed {
        logic [15:0] wait_n;
        logic        br_valid;
        logic [31:0] br_pc;
        logic        exc_valid;
        logic [31:0] exc_pc;
    } row_t;

    // wait_n counts instructions since the previous row
    // zero means a fixed pause instead
    row_t rows [n_rows] = '{
        '{16'd12, 1'b1, 32'hbfc0_0100, 1'b0, 32'h0},
        '{16'd9,  1'b1, 32'hbfc0_0204, 1'b0, 32'h0},
        '{16'd7,  1'b1, 32'hbfc0_0300, 1'b1, 32'hbfc0_0380},
        '{16'd10, 1'b0, 32'h0,         1'b1, 32'h8000_0180},
        '{16'd5,  1'b1, 32'h8000_0402, 1'b0, 32'h0},
        '{16'd0,  1'b1, 32'hbfc0_0500, 1'b0, 32'h0},
        '{16'd8,  1'b0, 32'h0,         1'b1, 32'hbfc0_0612},
        '{16'd0,  1'b1, 32'h9fc0_0700, 1'b0, 32'h0},
        '{16'd6,  1'b1, 32'hbfc0_0800, 1'b0, 32'h0}
    };

    logic                             clk = 1'b0;
    logic                             reset = 1'b1;
    logic                             i_exc_valid = 1'b0;
    logic [fetch_pkg::addr_w-1:0]     i_exc_pc = '0;
    logic                             i_branch_valid = 1'b0;
    logic [fetch_pkg::addr_w-1:0]     i_branch_pc = '0;
    logic                             o_ireq_valid;
    logic [fetch_pkg::addr_w-1:0]     o_ireq_addr;
    logic                             i_iresp_addr_ok = 1'b0;
    logic                             i_iresp_data_ok = 1'b0;
    logic [fetch_pkg::packet_w-1:0]   i_iresp_data = '0;
    logic                             o_inst_valid;
    logic [fetch_pkg::addr_w-1:0]     o_inst_pc;
    logic [fetch_pkg::inst_w-1:0]     o_inst_raw;
    logic                             o_inst_exc;
    logic                             i_inst_ready = 1'b0;

    int          delivered;
    int          check_errors;
    logic        halted;
    int          tb_errors = 0;
    int unsigned cyc = 0;
    int unsigned limit = 0;

    // bus model state
    integer                       seed = 32'he43557f1;
    logic                         stall = 1'b0;
    logic [fetch_pkg::addr_w-1:0] acc_addr [$];
    int unsigned                  acc_due [$];

    always #10 clk = ~clk;

    fetch_top dut0 (
        .clk, .reset, .i_exc_valid, .i_exc_pc, .i_branch_valid, .i_branch_pc,
        .o_ireq_valid, .o_ireq_addr, .i_iresp_addr_ok, .i_iresp_data_ok, .i_iresp_data,
        .o_inst_valid, .o_inst_pc, .o_inst_raw, .o_inst_exc, .i_inst_ready
    );

    fetch_checker #(.key(mem_key)) chk0 (
        .clk, .reset, .i_exc_valid, .i_exc_pc, .i_branch_valid, .i_branch_pc,
        .i_ireq_valid(o_ireq_valid), .i_addr_ok(i_iresp_addr_ok),
        .i_inst_valid(o_inst_valid), .i_inst_ready, .i_inst_pc(o_inst_pc),
        .i_inst_raw(o_inst_raw), .i_inst_exc(o_inst_exc),
        .o_delivered(delivered), .o_errors(check_errors), .o_halted(halted)
    );

    // instruction memory with random accept and 1 to 4 cycles of latency
    always @(negedge clk) begin
        logic [fetch_pkg::addr_w-1:0] a;
        if (reset) begin
            i_iresp_addr_ok = 1'b0;
            i_iresp_data_ok = 1'b0;
            i_inst_ready = 1'b0;
        end else begin
            if (acc_addr.size() > 0 && cyc >= acc_due[0]) begin
                a = acc_addr.pop_front();
                void'(acc_due.pop_front());
                i_iresp_data_ok = 1'b1;
                i_iresp_data = {(a + fetch_pkg::inst_bytes) ^ mem_key, a ^ mem_key};
            end else begin
                i_iresp_data_ok = 1'b0;
                i_iresp_data = '0;
            end
            i_iresp_addr_ok = (($unsigned($random(seed)) % 8) < 5) && !stall;
            if (o_ireq_valid && i_iresp_addr_ok) begin
                acc_addr.push_back(o_ireq_addr);
                acc_due.push_back(cyc + 1 + $unsigned($random(seed)) % 4);
            end
            // back-pressure about a quarter of the time
            i_inst_ready = ($unsigned($random(seed)) % 4) != 0;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= limit) begin
            $display("timeout: run still busy after %0d cycles", cyc);
            $display("Test failed");
            $finish;
        end
    end

    task automatic drive_redirect(input logic bv, input logic [31:0] bpc,
                                  input logic ev, input logic [31:0] epc);
        i_branch_valid = bv;
        i_branch_pc = bpc;
        i_exc_valid = ev;
        i_exc_pc = epc;
        @(negedge clk);
        i_branch_valid = 1'b0;
        i_exc_valid = 1'b0;
    endtask

    task automatic wait_for_count(input int n);
        int target;
        target = delivered + n;
        while (delivered < target) @(negedge clk);
    endtask

    // exception behind a stalled request and a branch that must not replace it
    task automatic drive_parked_exception(input logic [31:0] epc, input logic [31:0] bpc);
        stall <= 1'b1;
        @(negedge clk);
        while (!o_ireq_valid) @(negedge clk);
        drive_redirect(1'b0, '0, 1'b1, epc);
        drive_redirect(1'b1, bpc, 1'b0, '0);
        stall <= 1'b0;
    endtask

    initial begin
        int total;
        int r;
        total = parked_wait;
        for (r = 0; r < n_rows; r++) begin
            total += int'(rows[r].wait_n);
        end
        limit = 60 * total + 500;

        repeat (3) @(negedge clk);
        reset <= 1'b0;

        for (r = 0; r < n_rows; r++) begin
            if (rows[r].wait_n == 0) begin
                repeat (30) @(negedge clk);
                if (!halted) begin
                    tb_errors++;
                    $display("at %0t: misaligned target gave no exception instruction",
                             $time);
                end
            end else begin
                wait_for_count(int'(rows[r].wait_n));
            end
            drive_redirect(rows[r].br_valid, rows[r].br_pc, rows[r].exc_valid, rows[r].exc_pc);
        end

        drive_parked_exception(32'h8000_0380, 32'hbfc0_0900);
        wait_for_count(parked_wait);
        repeat (10) @(negedge clk);

        $display("errors: checker %0d, testbench %0d, instructions %0d",
                 check_errors, tb_errors, delivered);
        if (check_errors == 0 && tb_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- files.f
source/fetch_pkg.sv
source/pc_gen.sv
source/fetch_queue.sv
source/inst_split.sv
source/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --assert -Wno-fatal
TOP      := fetch_tb
FILELIST := files.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := Test completed successfully

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
